// ==== hw/soc_pkg.sv ====
// shared bus types, address map and reset values for the two-master fabric
// every design file refers to these by soc_pkg:: scoped names
`default_nettype none

package soc_pkg;

	typedef logic [31:0] word_t;
	// byte write strobes, all zero means a read
	typedef logic [3:0]  strb_t;
	typedef logic [0:0]  master_id_t;
	typedef logic [3:0]  region_t;
	typedef logic [7:0]  byte_t;
	typedef logic [5:0]  led_t;

	localparam int N_MASTERS = 2;
	typedef logic [N_MASTERS-1:0] cpu_run_t;

	typedef struct packed {
		logic  valid;
		word_t addr;
		word_t wdata;
		strb_t wstrb;
	} bus_req_t;

	typedef struct packed {
		word_t rdata;
		logic  ready;
	} bus_rsp_t;

	// address map, top nibble of the address
	localparam region_t REGION_UART = 4'h1;
	localparam region_t REGION_SYS  = 4'h2;
	localparam region_t REGION_RAM  = 4'h4;

	localparam int RAM_WORDS = 256;
	localparam int RAM_AW    = $clog2(RAM_WORDS);
	typedef logic [RAM_AW-1:0] ram_idx_t;

	localparam word_t BUS_ERR_DATA = 32'hdeadbeef;
	localparam int    IRQ_BUS_ERR  = 3;
	localparam word_t SOC_VERSION  = 32'h0000_0000;

	// reset values
	localparam word_t    UART_DIV_RESET  = 32'd16;
	localparam led_t     LED_RESET       = '0;
	localparam byte_t    PSRAM_OVR_RESET = '0;
	// cpu 0 runs out of reset, the others as well until software stops them
	localparam cpu_run_t CPU_RUN_RESET   = '1;

	typedef enum logic [1:0] {
		uart_idle,
		uart_start,
		uart_data,
		uart_stop
	} uart_state_t;

endpackage

`default_nettype wire

// ==== hw/bus_arbiter.sv ====
// round-robin arbiter between the two bus masters
// the granted master owns the shared port until it drops valid
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  wire                                               clk48m,
	input  wire                                               rst,
	input  soc_pkg::bus_req_t [soc_pkg::N_MASTERS-1:0]        m_req,
	output soc_pkg::bus_rsp_t [soc_pkg::N_MASTERS-1:0]        m_rsp,
	output soc_pkg::bus_req_t                                 s_req,
	input  soc_pkg::bus_rsp_t                                 s_rsp,
	output soc_pkg::master_id_t                               cur_master
);

	soc_pkg::master_id_t grant;
	soc_pkg::master_id_t other;

	// with two masters the next in turn is simply the other one
	assign other = grant + 1'b1;

	// grant only moves while the owner is idle, so a transfer in
	// flight is never cut off
	always_ff @(posedge clk48m) begin
		if (rst) begin
			grant <= '0;
		end else if (!m_req[grant].valid && m_req[other].valid) begin
			grant <= other;
		end
	end

	// non-granted master never reaches the decoder
	assign s_req = m_req[grant];

	// read data goes to everyone, ready only to the owner
	always_comb begin
		for (int i = 0; i < soc_pkg::N_MASTERS; i++) begin
			m_rsp[i].rdata = s_rsp.rdata;
			m_rsp[i].ready = s_rsp.ready && (grant == soc_pkg::master_id_t'(i));
		end
	end

	// software readback of which cpu is on the bus
	assign cur_master = grant;

endmodule

`default_nettype wire

// ==== hw/addr_decoder.sv ====
// address decode for the shared bus port
// drives target selects, muxes read data, combines ready, raises bus-error irq
`timescale 1ns/1ps
`default_nettype none

module addr_decoder (
	input  wire                clk48m,
	input  wire                rst,
	input  soc_pkg::bus_req_t  s_req,
	output soc_pkg::bus_rsp_t  s_rsp,
	output logic               ram_sel,
	output logic               uart_dat_sel,
	output logic               uart_div_sel,
	output logic               sys_sel,
	input  soc_pkg::word_t     ram_rdata,
	input  soc_pkg::word_t     uart_dat_rdata,
	input  soc_pkg::word_t     uart_div_rdata,
	input  soc_pkg::word_t     sys_rdata,
	input  wire                ram_ready,
	input  wire                dat_wait,
	output soc_pkg::word_t     irq
);

	soc_pkg::region_t region;
	soc_pkg::word_t   rd_mux;
	logic             bus_err;
	logic             rdy;

	assign region = s_req.addr[31:28];

	always_comb begin
		ram_sel      = 1'b0;
		uart_dat_sel = 1'b0;
		uart_div_sel = 1'b0;
		sys_sel      = 1'b0;
		bus_err      = 1'b0;
		rd_mux       = soc_pkg::BUS_ERR_DATA;
		case (region)
			soc_pkg::REGION_RAM: begin
				ram_sel = s_req.valid;
				rd_mux  = ram_rdata;
			end
			soc_pkg::REGION_UART: begin
				// bit 2 picks divider over data
				if (s_req.addr[2]) begin
					uart_div_sel = s_req.valid;
					rd_mux       = uart_div_rdata;
				end else begin
					uart_dat_sel = s_req.valid;
					rd_mux       = uart_dat_rdata;
				end
			end
			soc_pkg::REGION_SYS: begin
				sys_sel = s_req.valid;
				rd_mux  = sys_rdata;
			end
			// nothing mapped here, lcd region included
			default: bus_err = s_req.valid;
		endcase
	end

	// ram is the only target with latency, uart data may stall
	assign rdy = ram_ready || uart_div_sel || sys_sel ||
		(uart_dat_sel && !dat_wait) || bus_err;

	assign s_rsp = '{rdata: rd_mux, ready: rdy};

	// irq 3 pulses the cycle after an unmapped access
	always_ff @(posedge clk48m) begin
		if (rst) begin
			irq <= '0;
		end else begin
			irq <= '0;
			irq[soc_pkg::IRQ_BUS_ERR] <= bus_err;
		end
	end

endmodule

`default_nettype wire

// ==== hw/scratch_ram.sv ====
// on-chip scratch ram with byte write strobes
// one ready pulse per access, one cycle after select
`timescale 1ns/1ps
`default_nettype none

module scratch_ram (
	input  wire             clk48m,
	input  wire             rst,
	input  wire             sel,
	input  soc_pkg::word_t  addr,
	input  soc_pkg::word_t  wdata,
	input  soc_pkg::strb_t  wstrb,
	output soc_pkg::word_t  rdata,
	output logic            ready
);

	soc_pkg::word_t   mem [soc_pkg::RAM_WORDS];
	soc_pkg::ram_idx_t idx;

	// word index, byte offset dropped
	assign idx = addr[soc_pkg::RAM_AW+1:2];

	always_ff @(posedge clk48m) begin
		if (sel) begin
			for (int b = 0; b < $bits(soc_pkg::strb_t); b++) begin
				if (wstrb[b]) begin
					mem[idx][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
			rdata <= mem[idx];
		end
	end

	// forced low after a pulse so a held select does not complete twice
	always_ff @(posedge clk48m) begin
		if (rst) begin
			ready <= 1'b0;
		end else begin
			ready <= sel && !ready;
		end
	end

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
// uart transmitter with divider and data registers
// a data write stalls the bus while a frame is still going out
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input  wire             clk48m,
	input  wire             rst,
	input  wire             dat_sel,
	input  wire             div_sel,
	input  soc_pkg::strb_t  wstrb,
	input  soc_pkg::word_t  wdata,
	output soc_pkg::word_t  dat_rdata,
	output soc_pkg::word_t  div_rdata,
	output logic            dat_wait,
	output logic            tx
);

	soc_pkg::uart_state_t state;
	soc_pkg::word_t       div_reg;
	soc_pkg::word_t       cnt;
	soc_pkg::byte_t       shreg;
	logic [2:0]           bit_idx;
	logic                 bit_done;
	logic                 load;
	logic                 tx_next;

	// divider, one byte lane per strobe
	always_ff @(posedge clk48m) begin
		if (rst) begin
			div_reg <= soc_pkg::UART_DIV_RESET;
		end else if (div_sel) begin
			for (int b = 0; b < $bits(soc_pkg::strb_t); b++) begin
				if (wstrb[b]) begin
					div_reg[8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

	assign div_rdata = div_reg;
	// no receiver, reads see an empty line
	assign dat_rdata = '1;

	assign load     = dat_sel && wstrb[0] && (state == soc_pkg::uart_idle);
	assign dat_wait = dat_sel && wstrb[0] && (state != soc_pkg::uart_idle);
	assign bit_done = (cnt == div_reg - 1'b1);

	always_ff @(posedge clk48m) begin
		if (rst) begin
			state   <= soc_pkg::uart_idle;
			cnt     <= '0;
			bit_idx <= '0;
		end else begin
			if (state == soc_pkg::uart_idle || bit_done) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
			case (state)
				soc_pkg::uart_idle: begin
					if (load) begin
						state <= soc_pkg::uart_start;
					end
				end
				soc_pkg::uart_start: begin
					if (bit_done) begin
						bit_idx <= '0;
						state   <= soc_pkg::uart_data;
					end
				end
				soc_pkg::uart_data: begin
					if (bit_done) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= soc_pkg::uart_stop;
						end
					end
				end
				default: begin
					if (bit_done) begin
						state <= soc_pkg::uart_idle;
					end
				end
			endcase
		end
	end

	// lsb first, shifted at the end of each data bit
	always_ff @(posedge clk48m) begin
		if (load) begin
			shreg <= wdata[7:0];
		end else if (state == soc_pkg::uart_data && bit_done) begin
			shreg <= shreg >> 1;
		end
	end

	always_comb begin
		case (state)
			soc_pkg::uart_start: tx_next = 1'b0;
			soc_pkg::uart_data:  tx_next = shreg[0];
			default:             tx_next = 1'b1;
		endcase
	end

	// registered line, idles high
	always_ff @(posedge clk48m) begin
		if (rst) begin
			tx <= 1'b1;
		end else begin
			tx <= tx_next;
		end
	end

endmodule

`default_nettype wire

// ==== hw/sys_regs.sv ====
// system register block: leds, psram pin overrides, cpu run control
// index 0 reads the version word, index 1 the current bus master
`timescale 1ns/1ps
`default_nettype none

module sys_regs (
	input  wire                  clk48m,
	input  wire                  rst,
	input  wire                  sel,
	input  soc_pkg::word_t       addr,
	input  soc_pkg::word_t       wdata,
	input  soc_pkg::strb_t       wstrb,
	input  soc_pkg::master_id_t  cur_master,
	output soc_pkg::word_t       rdata,
	output soc_pkg::led_t        led,
	output soc_pkg::byte_t       psram_ovr_a,
	output soc_pkg::byte_t       psram_ovr_b,
	output soc_pkg::cpu_run_t    cpu_run
);

	logic [2:0] idx;

	assign idx = addr[4:2];

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led         <= soc_pkg::LED_RESET;
			psram_ovr_a <= soc_pkg::PSRAM_OVR_RESET;
			psram_ovr_b <= soc_pkg::PSRAM_OVR_RESET;
			cpu_run     <= soc_pkg::CPU_RUN_RESET;
		end else if (sel && wstrb[0]) begin
			case (idx)
				3'd0: led         <= wdata[5:0];
				3'd1: psram_ovr_a <= wdata[7:0];
				3'd2: psram_ovr_b <= wdata[7:0];
				// cpu 0 always runs, bit 0 not writable
				3'd3: cpu_run[soc_pkg::N_MASTERS-1:1] <= wdata[soc_pkg::N_MASTERS-1:1];
				default: ;
			endcase
		end
	end

	always_comb begin
		case (idx)
			3'd0:    rdata = soc_pkg::SOC_VERSION;
			3'd1:    rdata = soc_pkg::word_t'(cur_master);
			default: rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/soc_fabric.sv ====
// top of the two-master bus fabric
// arbiter feeds the decoder, which fans out to ram, uart and system registers
`timescale 1ns/1ps
`default_nettype none

module soc_fabric (
	input  wire                                          clk48m,
	input  wire                                          rst,
	input  soc_pkg::bus_req_t [soc_pkg::N_MASTERS-1:0]   m_req,
	output soc_pkg::bus_rsp_t [soc_pkg::N_MASTERS-1:0]   m_rsp,
	output soc_pkg::led_t                                led,
	output soc_pkg::byte_t                               psram_ovr_a,
	output soc_pkg::byte_t                               psram_ovr_b,
	output soc_pkg::cpu_run_t                            cpu_run,
	output soc_pkg::word_t                               irq,
	output wire                                          uart_tx
);

	soc_pkg::bus_req_t   s_req;
	soc_pkg::bus_rsp_t   s_rsp;
	soc_pkg::master_id_t cur_master;

	wire ram_sel;
	wire uart_dat_sel;
	wire uart_div_sel;
	wire sys_sel;
	wire ram_ready;
	wire dat_wait;

	soc_pkg::word_t ram_rdata;
	soc_pkg::word_t uart_dat_rdata;
	soc_pkg::word_t uart_div_rdata;
	soc_pkg::word_t sys_rdata;

	bus_arbiter u_arbiter (
		.clk48m     (clk48m),
		.rst        (rst),
		.m_req      (m_req),
		.m_rsp      (m_rsp),
		.s_req      (s_req),
		.s_rsp      (s_rsp),
		.cur_master (cur_master)
	);

	addr_decoder u_decoder (
		.clk48m         (clk48m),
		.rst            (rst),
		.s_req          (s_req),
		.s_rsp          (s_rsp),
		.ram_sel        (ram_sel),
		.uart_dat_sel   (uart_dat_sel),
		.uart_div_sel   (uart_div_sel),
		.sys_sel        (sys_sel),
		.ram_rdata      (ram_rdata),
		.uart_dat_rdata (uart_dat_rdata),
		.uart_div_rdata (uart_div_rdata),
		.sys_rdata      (sys_rdata),
		.ram_ready      (ram_ready),
		.dat_wait       (dat_wait),
		.irq            (irq)
	);

	scratch_ram u_ram (
		.clk48m (clk48m),
		.rst    (rst),
		.sel    (ram_sel),
		.addr   (s_req.addr),
		.wdata  (s_req.wdata),
		.wstrb  (s_req.wstrb),
		.rdata  (ram_rdata),
		.ready  (ram_ready)
	);

	uart_tx u_uart (
		.clk48m    (clk48m),
		.rst       (rst),
		.dat_sel   (uart_dat_sel),
		.div_sel   (uart_div_sel),
		.wstrb     (s_req.wstrb),
		.wdata     (s_req.wdata),
		.dat_rdata (uart_dat_rdata),
		.div_rdata (uart_div_rdata),
		.dat_wait  (dat_wait),
		.tx        (uart_tx)
	);

	sys_regs u_sys (
		.clk48m      (clk48m),
		.rst         (rst),
		.sel         (sys_sel),
		.addr        (s_req.addr),
		.wdata       (s_req.wdata),
		.wstrb       (s_req.wstrb),
		.cur_master  (cur_master),
		.rdata       (sys_rdata),
		.led         (led),
		.psram_ovr_a (psram_ovr_a),
		.psram_ovr_b (psram_ovr_b),
		.cpu_run     (cpu_run)
	);

endmodule

`default_nettype wire

// ==== verif/tb_soc_fabric.sv ====
// directed testbench for the two-master bus fabric
// plays both cpus on the master ports and decodes the uart line
`timescale 1ns/1ps
`default_nettype none

module tb_soc_fabric;

	// run budget: about 4 uart frames of 10 bits at divider 16, plus margin
	localparam int MAX_CYCLES = 20000;
	localparam logic [31:0] RAM_BASE = 32'h4000_0000;
	localparam logic [31:0] UART_DAT = 32'h1000_0000;
	localparam logic [31:0] UART_DIV = 32'h1000_0004;
	localparam logic [31:0] SYS_BASE = 32'h2000_0000;
	localparam logic [31:0] ERR_WORD = 32'hdead_beef;

	logic                                       clk48m;
	logic                                       rst;
	soc_pkg::bus_req_t [soc_pkg::N_MASTERS-1:0] m_req;
	soc_pkg::bus_rsp_t [soc_pkg::N_MASTERS-1:0] m_rsp;
	logic [5:0]                                 led;
	logic [7:0]                                 psram_ovr_a;
	logic [7:0]                                 psram_ovr_b;
	logic [1:0]                                 cpu_run;
	logic [31:0]                                irq;
	logic                                       uart_tx;

	integer      seed = 32'he58;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          owner = 0;
	logic        err_pending = 1'b0;
	logic [31:0] model [256];
	logic        written [256];

	soc_fabric u_dut (
		.clk48m      (clk48m),
		.rst         (rst),
		.m_req       (m_req),
		.m_rsp       (m_rsp),
		.led         (led),
		.psram_ovr_a (psram_ovr_a),
		.psram_ovr_b (psram_ovr_b),
		.cpu_run     (cpu_run),
		.irq         (irq),
		.uart_tx     (uart_tx)
	);

	initial clk48m = 1'b0;
	always #20 clk48m = ~clk48m;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic logic unmapped(input logic [31:0] addr);
		case (addr[31:28])
			4'h1, 4'h2, 4'h4: return 1'b0;
			default:          return 1'b1;
		endcase
	endfunction

	// strobed bytes of the new word replace those of the old one
	function automatic logic [31:0] merge(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] strb);
		logic [31:0] res;
		res = old_word;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				res[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return res;
	endfunction

	// cycles a ram access waits, one extra when the grant has to move
	function automatic int ram_latency(input int m);
		return (m == owner) ? 1 : 2;
	endfunction

	// one transfer: hold the request until ready, lat counts the wait cycles
	task automatic bus_access(input int m, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [3:0] strb,
		output logic [31:0] rdata, output int lat);
		soc_pkg::bus_req_t r;
		r.valid = 1'b1;
		r.addr  = addr;
		r.wdata = wdata;
		r.wstrb = strb;
		lat = 0;
		@(posedge clk48m);
		m_req[m] <= r;
		@(negedge clk48m);
		while (!m_rsp[m].ready) begin
			lat++;
			@(negedge clk48m);
		end
		rdata = m_rsp[m].rdata;
		@(posedge clk48m);
		r.valid = 1'b0;
		m_req[m] <= r;
		owner = m;
	endtask

	task automatic bus_write(input int m, input logic [31:0] addr,
		input logic [31:0] data, input logic [3:0] strb, output int lat);
		logic [31:0] unused;
		bus_access(m, addr, data, strb, unused, lat);
	endtask

	task automatic bus_read(input int m, input logic [31:0] addr,
		output logic [31:0] data, output int lat);
		bus_access(m, addr, 32'h0, 4'h0, data, lat);
	endtask

	// waits for a start bit, then samples each bit in its middle
	task automatic uart_receive(input int div, output logic [7:0] data,
		output time stop_time);
		@(negedge uart_tx);
		repeat (div / 2) @(negedge clk48m);
		check_value("uart_tx start bit", uart_tx, 1'b0);
		for (int i = 0; i < 8; i++) begin
			repeat (div) @(negedge clk48m);
			data[i] = uart_tx;
		end
		repeat (div) @(negedge clk48m);
		check_value("uart_tx stop bit", uart_tx, 1'b1);
		stop_time = $time;
	endtask

	task automatic ram_test();
		logic [3:0]  strbs [6] = '{4'h1, 4'h6, 4'h8, 4'hc, 4'h3, 4'h2};
		logic [7:0]  idx;
		logic [31:0] addr;
		logic [31:0] d;
		int          m;
		int          lat;
		int          exp_lat;
		for (int k = 0; k < 6; k++) begin
			idx  = $random(seed) & 8'h7f;
			addr = RAM_BASE | (32'(idx) << 2);
			m    = k % 2;
			d    = $random(seed);
			exp_lat = ram_latency(m);
			bus_write(m, addr, d, 4'hf, lat);
			check_value("ram write latency", lat, exp_lat);
			model[idx] = d;
			// partial write from the other master
			d = $random(seed);
			exp_lat = ram_latency(1 - m);
			bus_write(1 - m, addr, d, strbs[k], lat);
			check_value("ram strobed write latency", lat, exp_lat);
			model[idx] = merge(model[idx], d, strbs[k]);
			exp_lat = ram_latency(m);
			bus_read(m, addr, d, lat);
			check_value("ram read latency", lat, exp_lat);
			check_value("ram rdata", d, model[idx]);
		end
	endtask

	task automatic sys_test();
		logic [31:0] d;
		int          lat;
		bus_write(0, SYS_BASE, 32'hffff_ffea, 4'h1, lat);
		@(negedge clk48m);
		check_value("led", led, 6'h2a);
		bus_write(1, SYS_BASE + 4, 32'h0000_005a, 4'h1, lat);
		@(negedge clk48m);
		check_value("psram_ovr_a", psram_ovr_a, 8'h5a);
		bus_write(0, SYS_BASE + 8, 32'h0000_00a5, 4'h1, lat);
		@(negedge clk48m);
		check_value("psram_ovr_b", psram_ovr_b, 8'ha5);
		// cpu 0 keeps running whatever is written
		bus_write(0, SYS_BASE + 12, 32'h0, 4'h1, lat);
		@(negedge clk48m);
		check_value("cpu_run", cpu_run, 2'b01);
		bus_write(1, SYS_BASE + 12, 32'h2, 4'h1, lat);
		@(negedge clk48m);
		check_value("cpu_run", cpu_run, 2'b11);
		bus_read(0, SYS_BASE, d, lat);
		check_value("version word", d, 32'h0);
		bus_read(1, SYS_BASE + 4, d, lat);
		check_value("current master via master 1", d, 32'h1);
		bus_read(0, SYS_BASE + 4, d, lat);
		check_value("current master via master 0", d, 32'h0);
	endtask

	task automatic uart_test();
		logic [31:0] d;
		logic [7:0]  b0;
		logic [7:0]  b1;
		time         stop0;
		time         stop1;
		time         done1;
		int          lat;
		bus_write(0, UART_DIV, 32'd10, 4'hf, lat);
		bus_read(1, UART_DIV, d, lat);
		check_value("uart divider", d, 32'd10);
		bus_write(0, UART_DAT, 32'h0000_00a7, 4'h1, lat);
		uart_receive(10, b0, stop0);
		check_value("uart byte", b0, 8'ha7);
		bus_read(0, UART_DAT, d, lat);
		check_value("uart data read", d, 32'hffff_ffff);
		repeat (10) @(posedge clk48m);
		// back-to-back writes, the second stalls until the first frame is out
		fork
			begin
				uart_receive(10, b0, stop0);
				uart_receive(10, b1, stop1);
			end
			begin
				bus_write(0, UART_DAT, 32'h0000_003c, 4'h1, lat);
				bus_write(0, UART_DAT, 32'h0000_00c5, 4'h1, lat);
				done1 = $time;
			end
		join
		check_value("first stalled byte", b0, 8'h3c);
		check_value("second stalled byte", b1, 8'hc5);
		if (done1 < stop0) begin
			$display("second uart write finished at %0t ns, before the stop bit at %0t ns",
				done1, stop0);
			errors++;
		end
	endtask

	task automatic bus_error_test();
		logic [31:0] d;
		int          lat;
		bus_read(0, 32'h0000_0010, d, lat);
		check_value("region 0 rdata", d, ERR_WORD);
		@(negedge clk48m);
		check_value("irq after region 0 access", irq, 32'h8);
		@(negedge clk48m);
		check_value("irq one cycle later", irq, 32'h0);
		bus_read(1, 32'h3000_0000, d, lat);
		check_value("region 3 rdata", d, ERR_WORD);
		@(negedge clk48m);
		check_value("irq after region 3 access", irq, 32'h8);
		@(negedge clk48m);
		check_value("irq one cycle later", irq, 32'h0);
	endtask

	// each master owns its own half of the upper words
	task automatic master_traffic(input int m);
		logic [7:0]  idx;
		logic [31:0] d;
		int          lat;
		for (int n = 0; n < 12; n++) begin
			idx = 8'h80 | ((($random(seed) & 8'h3f) << 1) | m);
			d   = $random(seed);
			bus_write(m, RAM_BASE | (32'(idx) << 2), d, 4'hf, lat);
			model[idx]   = d;
			written[idx] = 1'b1;
		end
	endtask

	task automatic contention_test();
		logic [31:0] d;
		int          lat;
		fork
			master_traffic(0);
			master_traffic(1);
		join
		for (int i = 128; i < 256; i++) begin
			if (written[i]) begin
				bus_read(1 - (i % 2), RAM_BASE | (i << 2), d, lat);
				check_value("contention readback", d, model[i]);
			end
		end
	endtask

	// irq expected one cycle after an unmapped access, ready only to requesters
	always @(negedge clk48m) begin
		if (!rst) begin
			check_value("irq", irq, err_pending ? 32'h8 : 32'h0);
			err_pending = 1'b0;
			for (int i = 0; i < soc_pkg::N_MASTERS; i++) begin
				if (m_rsp[i].ready && !m_req[i].valid) begin
					$display("ready went to master %0d at %0t ns while it was not requesting",
						i, $time);
					errors++;
				end
				if (m_rsp[i].ready && m_req[i].valid && unmapped(m_req[i].addr)) begin
					err_pending = 1'b1;
				end
			end
		end
	end

	always @(posedge clk48m) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, the bus transfers did not finish", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		rst   = 1'b1;
		m_req = '0;
		for (int i = 0; i < 256; i++) begin
			written[i] = 1'b0;
		end
		repeat (8) @(posedge clk48m);
		rst <= 1'b0;
		ram_test();
		sys_test();
		uart_test();
		bus_error_test();
		contention_test();
		repeat (4) @(posedge clk48m);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/soc_pkg.sv
hw/bus_arbiter.sv
hw/addr_decoder.sv
hw/scratch_ram.sv
hw/uart_tx.sv
hw/sys_regs.sv
hw/soc_fabric.sv
verif/tb_soc_fabric.sv
